// File: hdl/rv32i_types.sv
`default_nettype none

package rv32i_types;

	// base opcodes, only op_reg and op_imm reach the arithmetic cluster
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,	// register-immediate alu ops
		op_reg   = 7'b0110011,	// register-register alu ops
		op_csr   = 7'b1110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		add  = 3'b000,	// add or sub, funct7 decides
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101,	// srl or sra
		aor  = 3'b110,
		aand = 3'b111
	} arith_funct3_t;

	typedef struct packed {
		logic [6:0]    funct7;
		logic [4:0]    rs2;
		logic [4:0]    rs1;
		arith_funct3_t funct3;
		logic [4:0]    rd;
		rv32i_opcode   opcode;
	} r_format_t;

	typedef struct packed {
		logic [11:0]   imm12;	// sign extended by the allocator
		logic [4:0]    rs1;
		arith_funct3_t funct3;
		logic [4:0]    rd;
		rv32i_opcode   opcode;
	} i_format_t;

	// one fetched word, viewed in either format
	typedef union packed {
		r_format_t r;
		i_format_t i;
	} instr_word_u;

endpackage : rv32i_types

`default_nettype wire

// File: hdl/ooo_types.sv
`default_nettype none

package ooo_types;

	parameter int WIDTH = 32;	// datapath width
	parameter int TAG_W = 3;	// rob tag width, 8 tags

	typedef logic [TAG_W-1:0] tag_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_t;

	// value is only meaningful once ready is set
	typedef struct packed {
		logic             ready;
		tag_t             tag;	// producer to wait on
		logic [WIDTH-1:0] value;
	} operand_t;

	// shared by the external bus and the cluster result bus
	typedef struct packed {
		logic             valid;
		tag_t             tag;
		logic [WIDTH-1:0] value;
	} cdb_t;

	typedef struct packed {
		alu_op_t  op;
		tag_t     dest;	// tag broadcast with the result
		operand_t src1;
		operand_t src2;
	} rs_payload_t;

	typedef logic [3:0] rs_count_t;	// free entry count, up to 15

endpackage : ooo_types

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  ooo_types::alu_op_t              op,
	input  logic [ooo_types::WIDTH-1:0]     a,
	input  logic [ooo_types::WIDTH-1:0]     b,
	output logic [ooo_types::WIDTH-1:0]     y
);
	import ooo_types::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];	// rv32i shifts use five bits

	always_comb begin
		case (op)
			alu_add:  y = a + b;
			alu_sub:  y = a - b;
			alu_sll:  y = a << shamt;
			alu_slt:  y = {{(WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: y = {{(WIDTH-1){1'b0}}, a < b};
			alu_xor:  y = a ^ b;
			alu_srl:  y = a >> shamt;
			alu_sra:  y = $unsigned($signed(a) >>> shamt);
			alu_or:   y = a | b;
			alu_and:  y = a & b;
			default:  y = '0;
		endcase
	end

endmodule : alu

`default_nettype wire

// File: hdl/rs_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module rs_dispatch #(
	parameter int rs_size = 8
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     dispatch,
	input  rv32i_types::instr_word_u instr,
	input  ooo_types::tag_t          dest_tag,
	input  ooo_types::operand_t      src1,
	input  ooo_types::operand_t      src2,
	input  logic [rs_size-1:0]       busy,
	output logic [rs_size-1:0]       alloc,
	output ooo_types::rs_payload_t   payload,
	output logic                     stall,
	output ooo_types::rs_count_t     num_available
);
	import rv32i_types::*;
	import ooo_types::*;

	logic               decode_ok;
	alu_op_t            op;
	operand_t           opnd2;
	logic [rs_size-1:0] first_free;
	rs_count_t          free_count;

	// alt is bit 30 of the word, read through whichever format applies
	function automatic alu_op_t arith_op(arith_funct3_t f3, logic alt, logic is_reg);
		case (f3)
			add:     return (alt && is_reg) ? alu_sub : alu_add;	// no subi in rv32i
			sll:     return alu_sll;
			slt:     return alu_slt;
			sltu:    return alu_sltu;
			axor:    return alu_xor;
			sr:      return alt ? alu_sra : alu_srl;
			aor:     return alu_or;
			aand:    return alu_and;
			default: return alu_add;
		endcase
	endfunction

	always_comb begin
		decode_ok = 1'b1;
		op        = alu_add;
		opnd2     = src2;
		case (instr.r.opcode)
			op_reg: begin
				op = arith_op(instr.r.funct3, instr.r.funct7[5], 1'b1);
			end
			op_imm: begin
				op          = arith_op(instr.i.funct3, instr.i.imm12[10], 1'b0);
				opnd2.ready = 1'b1;	// immediate never waits
				opnd2.tag   = '0;
				opnd2.value = {{(WIDTH-12){instr.i.imm12[11]}}, instr.i.imm12};
			end
			default: decode_ok = 1'b0;	// not an arithmetic op, ignored
		endcase
	end

	assign payload = '{op: op, dest: dest_tag, src1: src1, src2: opnd2};

	assign first_free = ~busy & (busy + 1'b1);	// lowest clear busy bit
	assign alloc      = (dispatch && decode_ok && !stall) ? first_free : '0;

	always_comb begin
		free_count = '0;
		for (int i = 0; i < rs_size; i++) begin
			free_count = free_count + rs_count_t'(!busy[i]);
		end
	end

	// count follows busy with one cycle of lag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			num_available <= rs_count_t'(rs_size);
		end else begin
			num_available <= free_count;
		end
	end

	assign stall = (num_available == '0);

endmodule : rs_dispatch

`default_nettype wire

// File: hdl/rs_entry.sv
`timescale 1ns/100ps
`default_nettype none

module rs_entry (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   alloc,
	input  logic                   grant,
	input  ooo_types::rs_payload_t payload,
	input  ooo_types::cdb_t        ext_cdb,
	input  ooo_types::cdb_t        result,
	output logic                   busy,
	output logic                   ready,
	output ooo_types::rs_payload_t entry
);
	import ooo_types::*;

	rs_payload_t base;
	rs_payload_t entry_next;

	// capture a broadcast value when its tag matches a waiting operand
	function automatic operand_t snoop(operand_t o, cdb_t bus_a, cdb_t bus_b);
		operand_t r;
		r = o;
		if (!o.ready) begin
			if (bus_a.valid && bus_a.tag == o.tag) begin
				r.ready = 1'b1;
				r.value = bus_a.value;
			end else if (bus_b.valid && bus_b.tag == o.tag) begin
				r.ready = 1'b1;
				r.value = bus_b.value;
			end
		end
		return r;
	endfunction

	assign base = alloc ? payload : entry;	// snoop also applies on the load edge

	always_comb begin
		entry_next      = base;
		entry_next.src1 = snoop(base.src1, ext_cdb, result);
		entry_next.src2 = snoop(base.src2, ext_cdb, result);
	end

	always_ff @(posedge clk) begin
		entry <= entry_next;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else if (alloc) begin
			busy <= 1'b1;
		end else if (grant) begin
			busy <= 1'b0;	// issued, slot is free again
		end
	end

	assign ready = busy && entry.src1.ready && entry.src2.ready;

endmodule : rs_entry

`default_nettype wire

// File: hdl/acu_issue.sv
`timescale 1ns/100ps
`default_nettype none

module acu_issue #(
	parameter int rs_size = 8
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [rs_size-1:0]     ready,
	input  ooo_types::rs_payload_t entry [rs_size],
	output logic [rs_size-1:0]     grant,
	output ooo_types::cdb_t        result
);
	import ooo_types::*;

	rs_payload_t      sel;
	logic [WIDTH-1:0] alu_y;
	logic             res_valid;
	tag_t             res_tag;
	logic [WIDTH-1:0] res_value;

	assign grant = ready & (~ready + 1'b1);	// lowest ready entry wins

	always_comb begin
		sel = '0;
		for (int i = 0; i < rs_size; i++) begin
			if (grant[i]) begin
				sel = entry[i];
			end
		end
	end

	alu u_alu (
		.op (sel.op),
		.a  (sel.src1.value),
		.b  (sel.src2.value),
		.y  (alu_y)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= |grant;	// one result per cycle at most
		end
	end

	always_ff @(posedge clk) begin
		res_tag   <= sel.dest;
		res_value <= alu_y;
	end

	assign result = '{valid: res_valid, tag: res_tag, value: res_value};

endmodule : acu_issue

`default_nettype wire

// File: hdl/acu_cluster.sv
`timescale 1ns/100ps
`default_nettype none

module acu_cluster #(
	parameter int rs_size = 8
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     dispatch,
	input  rv32i_types::instr_word_u instr,
	input  ooo_types::tag_t          dest_tag,
	input  ooo_types::operand_t      src1,
	input  ooo_types::operand_t      src2,
	input  ooo_types::cdb_t          ext_cdb,
	output ooo_types::cdb_t          result,
	output logic                     stall,
	output ooo_types::rs_count_t     num_available
);
	import ooo_types::*;

	logic [rs_size-1:0] alloc;
	logic [rs_size-1:0] busy;
	logic [rs_size-1:0] ready;
	logic [rs_size-1:0] grant;
	rs_payload_t        payload;
	rs_payload_t        entry [rs_size];

	rs_dispatch #(.rs_size(rs_size)) u_dispatch (
		.clk           (clk),
		.arst_n        (arst_n),
		.dispatch      (dispatch),
		.instr         (instr),
		.dest_tag      (dest_tag),
		.src1          (src1),
		.src2          (src2),
		.busy          (busy),
		.alloc         (alloc),
		.payload       (payload),
		.stall         (stall),
		.num_available (num_available)
	);

	for (genvar i = 0; i < rs_size; i++) begin : g_entry
		rs_entry u_entry (
			.clk     (clk),
			.arst_n  (arst_n),
			.alloc   (alloc[i]),
			.grant   (grant[i]),
			.payload (payload),
			.ext_cdb (ext_cdb),
			.result  (result),	// own results wake dependents too
			.busy    (busy[i]),
			.ready   (ready[i]),
			.entry   (entry[i])
		);
	end

	acu_issue #(.rs_size(rs_size)) u_issue (
		.clk    (clk),
		.arst_n (arst_n),
		.ready  (ready),
		.entry  (entry),
		.grant  (grant),
		.result (result)
	);

endmodule : acu_cluster

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int period     = 8,
	parameter int rst_cycles = 3
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(period/2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		#1 arst_n = 1'b1;	// release just after the third edge
	end

endmodule : tb_clock

`default_nettype wire

// File: tests/acu_issue_props.sv
`timescale 1ns/100ps
`default_nettype none

module acu_issue_props #(
	parameter int rs_size = 8
) (
	input logic               clk,
	input logic               arst_n,
	input logic [rs_size-1:0] ready,
	input logic [rs_size-1:0] grant,
	input ooo_types::cdb_t    result
);

	grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(grant))
		else $error("grant has more than one bit set");

	// a broadcast needs an issue in the previous cycle
	valid_after_grant: assert property (@(posedge clk) disable iff (!arst_n)
		result.valid |-> $past(|grant))
		else $error("result valid without a grant in the previous cycle");

	grant_only_ready: assert property (@(posedge clk) disable iff (!arst_n)
		(grant & ~ready) == '0)
		else $error("grant given to an entry that is not ready");

endmodule : acu_issue_props

`default_nettype wire

// File: tests/acu_cluster_tb.sv
`timescale 1ns/100ps
`default_nettype none

module acu_cluster_tb;
	import rv32i_types::*;
	import ooo_types::*;

	localparam int rs_size   = 8;
	localparam int n_tests   = 6;
	localparam int cyc_limit = n_tests * 300 + 100;

	logic        clk;
	logic        arst_n;
	logic        dispatch;
	instr_word_u instr;
	tag_t        dest_tag;
	operand_t    src1;
	operand_t    src2;
	cdb_t        ext_cdb;
	cdb_t        result;
	logic        stall;
	rs_count_t   num_available;

	integer   seed;
	int       cyc;
	int       errors;
	int       err_start;
	int       passed;
	int       failed;
	string    cur_test;
	logic     lat_on;
	tag_t     lat_tag;
	int       lat_start;

	// reference model, indexed by tag
	logic     inflight [8];
	logic     ext_res [8];	// tag owned by an outside producer
	alu_op_t  m_op [8];
	operand_t m_a [8];
	operand_t m_b [8];

	tb_clock #(.period(8), .rst_cycles(3)) u_clock (.clk(clk), .arst_n(arst_n));

	acu_cluster #(.rs_size(rs_size)) uut (
		.clk           (clk),
		.arst_n        (arst_n),
		.dispatch      (dispatch),
		.instr         (instr),
		.dest_tag      (dest_tag),
		.src1          (src1),
		.src2          (src2),
		.ext_cdb       (ext_cdb),
		.result        (result),
		.stall         (stall),
		.num_available (num_available)
	);

	bind acu_issue acu_issue_props #(.rs_size(rs_size)) u_props (
		.clk    (clk),
		.arst_n (arst_n),
		.ready  (ready),
		.grant  (grant),
		.result (result)
	);

	function automatic int rnd(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// rv32i semantics written from the ISA definitions
	function automatic logic [31:0] model_alu(alu_op_t op, logic [31:0] a,
		logic [31:0] b);
		logic [4:0] s;
		s = b[4:0];
		case (op)
			alu_add:  return a + b;
			alu_sub:  return a + ~b + 32'd1;
			alu_sll:  return a << s;
			alu_slt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
			alu_sltu: return {31'd0, a < b};
			alu_xor:  return a ^ b;
			alu_srl:  return a >> s;
			alu_sra:  return (a >> s) | ({32{a[31]}} & ~(32'hffff_ffff >> s));
			alu_or:   return a | b;
			default:  return a & b;
		endcase
	endfunction

	// funct3 field that encodes each operation
	function automatic arith_funct3_t funct3_of(alu_op_t op);
		case (op)
			alu_add, alu_sub: return add;
			alu_sll:          return sll;
			alu_slt:          return slt;
			alu_sltu:         return sltu;
			alu_xor:          return axor;
			alu_srl, alu_sra: return sr;
			alu_or:           return aor;
			default:          return aand;
		endcase
	endfunction

	function automatic int pick_tag(bit want_inflight, bit want_ext);
		int cand [$];
		bit hit;
		for (int i = 0; i < 8; i++) begin
			if (want_ext)
				hit = ext_res[i];
			else if (want_inflight)
				hit = inflight[i];
			else
				hit = !inflight[i] && !ext_res[i];
			if (hit)
				cand.push_back(i);
		end
		if (cand.size() == 0)
			return -1;
		return cand[rnd(cand.size())];
	endfunction

	task automatic check_result(string name, cdb_t exp, cdb_t act);
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected %0b/%0d/%h, actual %0b/%0d/%h (valid/tag/value)",
				name, exp.valid, exp.tag, exp.value, act.valid, act.tag, act.value);
		end
	endtask

	task automatic check_count(string name, rs_count_t exp, rs_count_t act);
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected num_available=%0d, actual num_available=%0d",
				name, exp, act);
		end
	endtask

	task automatic resolve(int t, logic [31:0] v);
		for (int i = 0; i < 8; i++) begin
			if (inflight[i] && !m_a[i].ready && m_a[i].tag == tag_t'(t))
				m_a[i] = '{ready: 1'b1, tag: m_a[i].tag, value: v};
			if (inflight[i] && !m_b[i].ready && m_b[i].tag == tag_t'(t))
				m_b[i] = '{ready: 1'b1, tag: m_b[i].tag, value: v};
		end
	endtask

	// results are matched by tag since they may come out of order
	always @(negedge clk) begin
		int t;
		cdb_t exp;
		if (arst_n && result.valid) begin
			t = int'(result.tag);
			if (!inflight[t]) begin
				errors++;
				$display("%s: result with tag %0d that no instruction in flight owns",
					cur_test, t);
			end else if (!m_a[t].ready || !m_b[t].ready) begin
				errors++;
				$display("%s: tag %0d issued before its operands were broadcast",
					cur_test, t);
			end else begin
				exp = '{valid: 1'b1, tag: tag_t'(t),
					value: model_alu(m_op[t], m_a[t].value, m_b[t].value)};
				check_result(cur_test, exp, result);
				inflight[t] = 1'b0;
				resolve(t, exp.value);
			end
			if (lat_on && result.tag == lat_tag) begin
				lat_on = 1'b0;
				if (cyc - lat_start != 2) begin
					errors++;
					$display("%s: lone dispatch took %0d cycles instead of 2",
						cur_test, cyc - lat_start);
				end
			end
		end
	end

	always @(posedge clk) begin
		cyc++;
		if (cyc >= cyc_limit) begin
			$display("timeout after %0d cycles, the tests did not complete", cyc);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic cycle_step();
		@(posedge clk);
		#1;
		dispatch = 1'b0;
		ext_cdb  = '0;
	endtask

	task automatic load_instr(int t, instr_word_u iw, alu_op_t op, operand_t a, operand_t b);
		dispatch    = 1'b1;
		instr       = iw;
		dest_tag    = tag_t'(t);
		src1        = a;
		src2        = b;
		inflight[t] = 1'b1;
		m_op[t]     = op;
		m_a[t]      = a;
		m_b[t]      = b;
	endtask

	function automatic operand_t wait_operand(int kind, int t, operand_t o);
		int w;
		w = -1;
		if (kind == 4 && rnd(2) == 1) begin
			w = pick_tag(1'b0, 1'b0);
			if (w == t)
				w = -1;
			if (w >= 0)
				ext_res[w] = 1'b1;
		end else if (kind == 5 && rnd(2) == 1) begin
			w = pick_tag(1'b1, 1'b0);	// chain onto an instruction in flight
		end
		if (w < 0)
			return o;
		return '{ready: 1'b0, tag: tag_t'(w), value: '0};
	endfunction

	task automatic issue_one(int kind);
		int          t;
		int          n;
		logic [11:0] imm;
		instr_word_u iw;
		alu_op_t     op;
		operand_t    a;
		operand_t    b;
		t = pick_tag(1'b0, 1'b0);
		if (t < 0)
			return;
		imm = 12'($random(seed));
		a   = '{ready: 1'b1, tag: '0, value: $random(seed)};
		b   = '{ready: 1'b1, tag: '0, value: $random(seed)};
		if (kind == 3) begin
			n  = rnd(9);
			op = alu_op_t'((n >= int'(alu_sub)) ? n + 1 : n);	// no subi in the ISA
			if (op == alu_sll || op == alu_srl)
				imm = {7'd0, imm[4:0]};
			else if (op == alu_sra)
				imm = {7'b0100000, imm[4:0]};
			iw.i = '{imm12: imm, rs1: 5'(rnd(32)), funct3: funct3_of(op),
				rd: 5'(rnd(32)), opcode: op_imm};
			b    = '{ready: 1'b1, tag: '0, value: {{20{imm[11]}}, imm}};
		end else begin
			op   = alu_op_t'(rnd(10));
			iw.r = '{funct7: (op == alu_sub || op == alu_sra) ? 7'b0100000 : 7'd0,
				rs2: 5'(rnd(32)), rs1: 5'(rnd(32)), funct3: funct3_of(op),
				rd: 5'(rnd(32)), opcode: op_reg};
		end
		a = wait_operand(kind, t, a);
		if (kind != 3)
			b = wait_operand(kind, t, b);
		load_instr(t, iw, op, a, b);
	endtask

	task automatic send_ext();
		int          e;
		logic [31:0] v;
		e = pick_tag(1'b0, 1'b1);
		if (e < 0)
			return;
		v          = $random(seed);
		ext_cdb    = '{valid: 1'b1, tag: tag_t'(e), value: v};
		ext_res[e] = 1'b0;
		resolve(e, v);
	endtask

	function automatic int busy_tags();
		int n;
		n = 0;
		for (int i = 0; i < 8; i++) begin
			n += int'(inflight[i]) + int'(ext_res[i]);
		end
		return n;
	endfunction

	task automatic drain();
		int n;
		int left;
		n = 0;
		while (busy_tags() != 0 && n < 200) begin
			cycle_step();
			send_ext();
			n++;
		end
		repeat (3) cycle_step();	// let the free count settle
		left = busy_tags();
		if (left != 0) begin
			errors++;
			$display("%s: %0d results never arrived", cur_test, left);
		end
	endtask

	task automatic begin_test(string name);
		cur_test  = name;
		err_start = errors;
	endtask

	task automatic end_test();
		if (errors == err_start) begin
			passed++;
			$display("test %s passed", cur_test);
		end else begin
			failed++;
			$display("test %s failed with %0d errors", cur_test, errors - err_start);
		end
	endtask

	task automatic run_random(string name, int kind, int n);
		begin_test(name);
		if (kind == 2) begin
			cycle_step();
			issue_one(2);
			lat_on    = 1'b1;
			lat_tag   = dest_tag;
			lat_start = cyc;
		end
		for (int k = 0; k < n; k++) begin
			cycle_step();
			if (!stall && rnd(4) != 0)
				issue_one(kind);
			if (kind == 4 && rnd(3) == 0)
				send_ext();	// may hit the dispatch edge itself
		end
		drain();
		if (lat_on) begin
			errors++;
			$display("%s: lone dispatch produced no result", cur_test);
		end
		end_test();
	endtask

	task automatic run_full();
		instr_word_u iw;
		operand_t    a;
		operand_t    b;
		begin_test("full_stall");
		iw.r = '{funct7: 7'd0, rs2: 5'd2, rs1: 5'd1, funct3: add, rd: 5'd3, opcode: op_reg};
		a    = '{ready: 1'b0, tag: 3'd7, value: '0};
		for (int k = 0; k < 8; k++) begin
			cycle_step();
			b = '{ready: 1'b1, tag: '0, value: $random(seed)};
			load_instr(k, iw, alu_add, a, b);
		end
		ext_res[7] = 1'b1;
		repeat (2) cycle_step();
		check_count(cur_test, 4'd0, num_available);
		if (stall !== 1'b1) begin
			errors++;
			$display("%s: stall is not high with every entry busy", cur_test);
		end
		send_ext();	// every entry wakes at the next edge
		repeat (2) cycle_step();
		// entry 0 has just issued but the registered count still reads zero
		check_count(cur_test, 4'd0, num_available);
		iw.r.funct3 = axor;
		b           = '{ready: 1'b1, tag: '0, value: 32'h5a5a_0f0f};
		dispatch    = 1'b1;	// dropped, a second tag 0 result would expose it
		instr       = iw;
		dest_tag    = 3'd0;
		src1        = b;
		src2        = b;
		cycle_step();
		drain();
		repeat (6) cycle_step();
		check_count(cur_test, 4'(rs_size), num_available);
		end_test();
	endtask

	initial begin
		seed     = 20;
		cyc      = 0;
		errors   = 0;
		passed   = 0;
		failed   = 0;
		lat_on   = 1'b0;
		lat_tag  = '0;
		dispatch = 1'b0;
		instr    = '0;
		dest_tag = '0;
		src1     = '0;
		src2     = '0;
		ext_cdb  = '0;
		cur_test = "reset";
		for (int i = 0; i < 8; i++) begin
			inflight[i] = 1'b0;
			ext_res[i]  = 1'b0;
		end

		wait (arst_n === 1'b1);
		begin_test("reset");
		check_count(cur_test, 4'(rs_size), num_available);
		if (stall !== 1'b0 || result.valid !== 1'b0) begin
			errors++;
			$display("%s: stall or result valid is high after reset", cur_test);
		end
		end_test();

		run_random("r_type_ready", 2, 40);
		run_random("i_type_imm", 3, 40);
		run_random("ext_wakeup", 4, 60);
		run_random("result_chain", 5, 60);
		run_full();

		$display("tests passed %0d failed %0d", passed, failed);
		if (failed == 0 && errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule : acu_cluster_tb

`default_nettype wire

// File: compile.f
hdl/rv32i_types.sv
hdl/ooo_types.sv
hdl/alu.sv
hdl/rs_dispatch.sv
hdl/rs_entry.sv
hdl/acu_issue.sv
hdl/acu_cluster.sv
tests/tb_clock.sv
tests/acu_issue_props.sv
tests/acu_cluster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cluster testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module acu_cluster_tb \
	--Mdir obj_dir \
	-o acu_sim

./obj_dir/acu_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
else
	exit 1
fi
